//--- hdl/block_pkg.sv
/* shared types and constants for the block placer; the field is 120 by 120 with 7-bit coordinates
   and QUEUE_DEPTH must be a power of two, at least 2 */
`default_nettype none

package block_pkg;

	// ##############################
	// types
	// ##############################

	typedef logic [6:0] coord_t;       // playing field coordinate
	typedef logic [2:0] colour_t;      // rgb, one bit each
	typedef logic [7:0] key_code_t;    // ps2 scan code
	typedef logic [5:0] pixel_index_t; // pixel number within a bar, 0..59

	// mover FSM
	typedef enum logic [1:0] {
		IDLE,    // waiting for the first start
		PLACING, // arrow keys move the bar
		SETTLED  // bar is set, keys ignored until start
	} mover_state_t;

	// ##############################
	// ps2 scan codes
	// ##############################

	localparam key_code_t KEY_LEFT  = 8'h6b;
	localparam key_code_t KEY_RIGHT = 8'h74;
	localparam key_code_t KEY_UP    = 8'h75;
	localparam key_code_t KEY_DOWN  = 8'h72;
	localparam key_code_t KEY_SPACE = 8'h29;

	// colours
	localparam colour_t COLOUR_BLACK = 3'b000; // erase
	localparam colour_t COLOUR_RED   = 3'b100; // bar being placed
	localparam colour_t COLOUR_PINK  = 3'b101; // bar that is set

	// ##############################
	// field geometry
	// ##############################

	localparam coord_t HOME_X    = 7'd8;   // top-left after start
	localparam coord_t HOME_Y    = 7'd7;
	localparam coord_t MIN_X     = 7'd8;   // lowest top-left x
	localparam coord_t MIN_Y     = 7'd4;   // lowest top-left y
	localparam coord_t FIELD_MAX = 7'd115; // far edge limit on both axes

	// bar size, long side and short side
	localparam int BAR_LEN   = 30;
	localparam int BAR_THICK = 2;

	localparam pixel_index_t BAR_PIXELS = 6'd60; // BAR_LEN * BAR_THICK

	// command queue depth used when the top level does not override it
	localparam int DEFAULT_QUEUE_DEPTH = 4;

endpackage

`default_nettype wire

//--- hdl/block_mover.sv
/* keys are dropped while a draw is pending, while no_room is high, or outside PLACING;
   orientation is sampled at start only */
`timescale 1ns/1ps
`default_nettype none

module block_mover (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start,        // begin a new placement
	input  logic                 vertical,     // orientation, sampled at start
	input  block_pkg::key_code_t key_data,
	input  logic                 key_pressed,  // one-cycle strobe, key_data valid
	input  logic                 no_room,      // queue has fewer than two free slots
	output logic                 push,
	output block_pkg::coord_t    cmd_x,
	output block_pkg::coord_t    cmd_y,
	output block_pkg::colour_t   cmd_colour,
	output logic                 cmd_vertical,
	output block_pkg::coord_t    block_x,      // current top-left of the bar
	output block_pkg::coord_t    block_y,
	output logic                 block_set     // bar has been set with space
);
	import block_pkg::*;

	mover_state_t state;
	logic         bar_vertical; // orientation latched at start
	logic         pend_draw;    // red draw owed after an erase

	coord_t lim_x;              // highest top-left x for this orientation
	coord_t lim_y;
	coord_t new_x;
	coord_t new_y;
	logic   move_ok;            // arrow key that stays in bounds
	logic   key_ok;             // key strobe that may be acted on
	logic   is_space;

	// next command
	logic    issue;
	coord_t  nxt_x;
	coord_t  nxt_y;
	colour_t nxt_colour;
	logic    nxt_vertical;

	// ##############################
	// bounds and key decode
	// ##############################

	// far edge = top-left + size - 1 must stay at or below FIELD_MAX
	assign lim_x = bar_vertical ? coord_t'(FIELD_MAX - BAR_THICK + 1)
	                            : coord_t'(FIELD_MAX - BAR_LEN + 1);
	assign lim_y = bar_vertical ? coord_t'(FIELD_MAX - BAR_LEN + 1)
	                            : coord_t'(FIELD_MAX - BAR_THICK + 1);

	assign key_ok   = key_pressed && (state == PLACING) && !no_room && !pend_draw;
	assign is_space = (key_data == KEY_SPACE);

	// one pixel per key, compare old position so nothing wraps
	always_comb begin
		new_x   = block_x;
		new_y   = block_y;
		move_ok = 1'b0;
		case (key_data)
			KEY_LEFT: begin
				new_x   = block_x - 7'd1;
				move_ok = (block_x > MIN_X);
			end
			KEY_RIGHT: begin
				new_x   = block_x + 7'd1;
				move_ok = (block_x < lim_x);
			end
			KEY_UP: begin
				new_y   = block_y - 7'd1;
				move_ok = (block_y > MIN_Y);
			end
			KEY_DOWN: begin
				new_y   = block_y + 7'd1;
				move_ok = (block_y < lim_y);
			end
			default: move_ok = 1'b0; // other codes do nothing
		endcase
	end

	// ##############################
	// command select
	// ##############################

	always_comb begin
		issue        = 1'b0;
		nxt_x        = block_x;
		nxt_y        = block_y;
		nxt_colour   = COLOUR_RED;
		nxt_vertical = bar_vertical;
		if (start) begin
			issue        = !no_room;     // home draw lost when queue is near full
			nxt_x        = HOME_X;
			nxt_y        = HOME_Y;
			nxt_vertical = vertical;
		end else if (pend_draw) begin
			issue = 1'b1;                // red at the new spot, block_x already moved
		end else if (key_ok && is_space) begin
			issue      = 1'b1;
			nxt_colour = COLOUR_PINK;
		end else if (key_ok && move_ok) begin
			issue      = 1'b1;
			nxt_colour = COLOUR_BLACK;   // erase at the old spot
		end
	end

	// control state
	always_ff @(posedge clk) begin
		if (reset_n) begin
			state        <= IDLE;
			push         <= 1'b0;
			pend_draw    <= 1'b0;
			block_set    <= 1'b0;
			bar_vertical <= 1'b0;
			block_x      <= HOME_X;
			block_y      <= HOME_Y;
		end else begin
			push      <= issue;
			pend_draw <= 1'b0;
			if (start) begin
				state        <= PLACING;
				bar_vertical <= vertical;
				block_x      <= HOME_X;
				block_y      <= HOME_Y;
				block_set    <= 1'b0;
			end else if (key_ok && is_space) begin
				state     <= SETTLED;
				block_set <= 1'b1;
			end else if (key_ok && move_ok) begin
				block_x   <= new_x; // updates with the erase push
				block_y   <= new_y;
				pend_draw <= 1'b1;
			end
		end
	end

	// command payload, only meaningful with push
	always_ff @(posedge clk) begin
		if (issue) begin
			cmd_x        <= nxt_x;
			cmd_y        <= nxt_y;
			cmd_colour   <= nxt_colour;
			cmd_vertical <= nxt_vertical;
		end
	end

endmodule

`default_nettype wire

//--- hdl/draw_queue.sv
/* first-word-fall-through; no_room counts the command pushed this cycle as taken,
   pushes when full and pops when empty are ignored */
`timescale 1ns/1ps
`default_nettype none

module draw_queue #(
	parameter int QUEUE_DEPTH = block_pkg::DEFAULT_QUEUE_DEPTH // power of two, >= 2
) (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               push,
	input  block_pkg::coord_t  cmd_x,
	input  block_pkg::coord_t  cmd_y,
	input  block_pkg::colour_t cmd_colour,
	input  logic               cmd_vertical,
	input  logic               pop,
	output block_pkg::coord_t  q_x,      // head command, valid while !empty
	output block_pkg::coord_t  q_y,
	output block_pkg::colour_t q_colour,
	output logic               q_vertical,
	output logic               empty,
	output logic               no_room
);
	import block_pkg::*;

	localparam int PTR_W = $clog2(QUEUE_DEPTH);
	localparam int CMD_W = 2 * $bits(coord_t) + $bits(colour_t) + 1;

	logic [CMD_W-1:0] mem [QUEUE_DEPTH]; // x, y, colour, vertical side by side
	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W:0]   count;             // occupancy, 0..QUEUE_DEPTH
	logic             full;
	logic             wr_en;
	logic             rd_en;

	assign full  = (int'(count) == QUEUE_DEPTH);
	assign empty = (count == '0);
	// two slots needed for an erase plus draw, in-flight push included
	assign no_room = (int'(count) + int'(push)) > (QUEUE_DEPTH - 2);

	assign wr_en = push && !full;
	assign rd_en = pop && !empty;

	// head word straight out of the array
	assign {q_x, q_y, q_colour, q_vertical} = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_ptr] <= {cmd_x, cmd_y, cmd_colour, cmd_vertical};
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (reset_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr_en)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd_en)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr_en, rd_en})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count; // none, or one in and one out
			endcase
		end
	end

endmodule

`default_nettype wire

//--- hdl/block_raster.sv
/* one pixel per cycle, 60 per bar in index order; one dead cycle after each bar
   so a bar takes 62 cycles from pop to the next possible pop */
`timescale 1ns/1ps
`default_nettype none

module block_raster (
	input  logic               clk,
	input  logic               reset_n,
	input  logic               empty,
	input  block_pkg::coord_t  q_x,
	input  block_pkg::coord_t  q_y,
	input  block_pkg::colour_t q_colour,
	input  logic               q_vertical,
	output logic               pop,
	output block_pkg::coord_t  xout,
	output block_pkg::coord_t  yout,
	output block_pkg::colour_t colourout,
	output logic               plot
);
	import block_pkg::*;

	// ##############################
	// latched command
	// ##############################

	coord_t  base_x;     // top-left of the bar being drawn
	coord_t  base_y;
	colour_t bar_colour;
	logic    bar_vert;

	// ##############################
	// raster state
	// ##############################

	logic         active;   // plotting a bar
	logic         gap;      // dead cycle after the last pixel
	pixel_index_t idx;      // pixel number, 0..59
	coord_t       col;      // offset along x
	coord_t       row;      // offset along y
	coord_t       col_last; // last column of a row for this orientation

	// take the head as soon as idle, head is already valid when !empty
	assign pop = !active && !gap && !empty;

	// rows are 30 wide horizontal, 2 wide vertical
	assign col_last = bar_vert ? coord_t'(BAR_THICK - 1) : coord_t'(BAR_LEN - 1);

	assign xout      = base_x + col;
	assign yout      = base_y + row;
	assign colourout = bar_colour;
	assign plot      = active;

	always_ff @(posedge clk) begin
		if (reset_n) begin
			active <= 1'b0;
			gap    <= 1'b0;
			idx    <= '0;
			col    <= '0;
			row    <= '0;
		end else begin
			gap <= 1'b0;
			if (pop) begin
				active <= 1'b1; // plot rises next cycle
				idx    <= '0;
				col    <= '0;
				row    <= '0;
			end else if (active) begin
				if (idx == BAR_PIXELS - 6'd1) begin
					active <= 1'b0;
					gap    <= 1'b1;
				end
				idx <= idx + 1'b1;
				// column/row pair stands in for i mod w and i div w
				if (col == col_last) begin
					col <= '0;
					row <= row + 7'd1;
				end else begin
					col <= col + 7'd1;
				end
			end
		end
	end

	// command payload, loaded with the pop
	always_ff @(posedge clk) begin
		if (pop) begin
			base_x     <= q_x;
			base_y     <= q_y;
			bar_colour <= q_colour;
			bar_vert   <= q_vertical;
		end
	end

endmodule

`default_nettype wire

//--- hdl/block_placer.sv
/* top of the block placer; key_pressed must be a one-cycle strobe in the clk domain */
`timescale 1ns/1ps
`default_nettype none

module block_placer #(
	parameter int QUEUE_DEPTH = block_pkg::DEFAULT_QUEUE_DEPTH // pending draw commands
) (
	input  logic                 clk,
	input  logic                 reset_n,
	input  logic                 start,
	input  logic                 vertical,
	input  block_pkg::key_code_t key_data,
	input  logic                 key_pressed,
	output block_pkg::coord_t    xout,      // pixel stream to the vga adapter
	output block_pkg::coord_t    yout,
	output block_pkg::colour_t   colourout,
	output logic                 plot,
	output block_pkg::coord_t    block_x,   // bar position for the game logic
	output block_pkg::coord_t    block_y,
	output logic                 block_set
);
	import block_pkg::*;

	// mover to queue
	logic    push;
	coord_t  cmd_x;
	coord_t  cmd_y;
	colour_t cmd_colour;
	logic    cmd_vertical;
	logic    no_room;

	// queue to raster
	logic    pop;
	logic    empty;
	coord_t  q_x;
	coord_t  q_y;
	colour_t q_colour;
	logic    q_vertical;

	// keys in, draw commands out
	block_mover i_mover (
		.clk         (clk),
		.reset_n     (reset_n),
		.start       (start),
		.vertical    (vertical),
		.key_data    (key_data),
		.key_pressed (key_pressed),
		.no_room     (no_room),
		.push        (push),
		.cmd_x       (cmd_x),
		.cmd_y       (cmd_y),
		.cmd_colour  (cmd_colour),
		.cmd_vertical(cmd_vertical),
		.block_x     (block_x),
		.block_y     (block_y),
		.block_set   (block_set)
	);

	draw_queue #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_queue (
		.clk         (clk),
		.reset_n     (reset_n),
		.push        (push),
		.cmd_x       (cmd_x),
		.cmd_y       (cmd_y),
		.cmd_colour  (cmd_colour),
		.cmd_vertical(cmd_vertical),
		.pop         (pop),
		.q_x         (q_x),
		.q_y         (q_y),
		.q_colour    (q_colour),
		.q_vertical  (q_vertical),
		.empty       (empty),
		.no_room     (no_room)
	);

	// commands in, pixels out
	block_raster i_raster (
		.clk       (clk),
		.reset_n   (reset_n),
		.empty     (empty),
		.q_x       (q_x),
		.q_y       (q_y),
		.q_colour  (q_colour),
		.q_vertical(q_vertical),
		.pop       (pop),
		.xout      (xout),
		.yout      (yout),
		.colourout (colourout),
		.plot      (plot)
	);

endmodule

`default_nettype wire

//--- testbench/tb_pixel_checker.sv
/* compares every plotted pixel with the expected stream, in order; samples on the falling edge
   and the testbench fills the queue ahead of the raster */
`timescale 1ns/1ps
`default_nettype none

module tb_pixel_checker (
	input logic               clk,
	input logic               plot,
	input block_pkg::coord_t  xout,
	input block_pkg::coord_t  yout,
	input block_pkg::colour_t colourout
);
	import block_pkg::*;

	logic [16:0] exp_q [$];     // {x, y, colour} in plot order
	logic [16:0] want;          // head of exp_q for this cycle
	int          err_count = 0; // wrong or unexpected pixels
	int          checked   = 0; // pixels compared

	// called by the reference model, one entry per pixel
	function automatic void expect_pixel(input coord_t x, input coord_t y, input colour_t c);
		exp_q.push_back({x, y, c});
	endfunction

	function automatic int pending();
		return exp_q.size();
	endfunction

	// drop what is left after a stream went missing
	function automatic void flush();
		exp_q.delete();
	endfunction

	function automatic void check_field(input string name, input int exp, input logic [6:0] got);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s expected %0d got %0d", $time, name, exp, got);
			err_count++;
		end
	endfunction

	// ##############################
	// compare on every plot cycle
	// ##############################

	always @(negedge clk) begin
		if (plot === 1'b1) begin
			if (exp_q.size() == 0) begin
				$display("%0d ns: a pixel was plotted at (%0d, %0d) but none was expected",
				         $time, xout, yout);
				err_count++;
			end else begin
				want = exp_q.pop_front();
				checked++;
				check_field("xout", want[16:10], xout);
				check_field("yout", want[9:3], yout);
				check_field("colourout", want[2:0], colourout); // 3 bits, shown in decimal
			end
		end
	end

endmodule

`default_nettype wire

//--- testbench/tb_block_asserts.sv
/* bound into the top level, the full flag is taken from the queue instance;
   all checks are off while reset_n is high */
`timescale 1ns/1ps
`default_nettype none

module tb_block_asserts (
	input logic clk,
	input logic reset_n,
	input logic start,
	input logic push,
	input logic full,
	input logic pop,
	input logic empty,
	input logic plot,
	input logic block_set
);
	int fail_count = 0; // summed into the test results

	// queue is never written while full
	a_push_full: assert property (@(posedge clk) disable iff (reset_n) !(push && full))
		else begin
			fail_count++;
			$error("push while the queue is full");
		end

	// a pushed command is at the head on the next cycle
	a_push_seen: assert property (@(posedge clk) disable iff (reset_n) push |=> !empty)
		else begin
			fail_count++;
			$error("a pushed command did not reach the queue");
		end

	// 60 pixels after each pop, then a gap
	a_plot_len: assert property (@(posedge clk) disable iff (reset_n)
		pop |=> plot [*60] ##1 !plot)
		else begin
			fail_count++;
			$error("plot did not stay high for exactly 60 cycles after a pop");
		end

	a_set_hold: assert property (@(posedge clk) disable iff (reset_n)
		$fell(block_set) |-> $past(start)) // only start clears a set bar
		else begin
			fail_count++;
			$error("block_set fell without a start");
		end

endmodule

bind block_placer tb_block_asserts i_asserts (
	.clk      (clk),
	.reset_n  (reset_n),
	.start    (start),
	.push     (push),
	.full     (i_queue.full),
	.pop      (pop),
	.empty    (empty),
	.plot     (plot),
	.block_set(block_set)
);

`default_nettype wire

//--- testbench/tb_block_placer.sv
/* drives keys 1 ns after the rising edge and predicts queue drops from push and pop times;
   the queue depth of the model must match the one given to the DUT */
`timescale 1ns/1ps
`default_nettype none

module tb_block_placer;
	import block_pkg::*;

	localparam int QUEUE_DEPTH = 4;
	localparam int KEY_GAP     = 130;  // two bars of 62 cycles fit between keys
	localparam int RASTER_T    = 62;   // pop to next possible pop
	// six tests of up to 40 keys, plus two walks across the whole field
	localparam int KEY_BUDGET     = 6 * 40 + 2 * (2 * 120);
	localparam int TIMEOUT_CYCLES = KEY_BUDGET * KEY_GAP + 2000;

	logic      clk;
	logic      reset_n;
	logic      start;
	logic      vertical;
	key_code_t key_data;
	logic      key_pressed;
	coord_t    xout;
	coord_t    yout;
	colour_t   colourout;
	logic      plot;
	coord_t    block_x;
	coord_t    block_y;
	logic      block_set;

	int cyc = 0;       // cycle n follows rising edge n
	int errors;        // position and drain errors
	int base_err;      // error total at the start of the test
	int passed;
	int failed;

	// ##############################
	// reference model state
	// ##############################

	mover_state_t m_state;
	coord_t       m_x;
	coord_t       m_y;
	logic         m_vert;
	logic         m_set;
	int           wr_edge [$]; // edge at which each command is written
	int           pop_cyc [$]; // cycle in which the raster takes it
	int           last_move;   // cycle of the last accepted arrow
	logic [31:0]  rng;

	block_placer #(
		.QUEUE_DEPTH(QUEUE_DEPTH)
	) i_dut (
		.clk        (clk),
		.reset_n    (reset_n),
		.start      (start),
		.vertical   (vertical),
		.key_data   (key_data),
		.key_pressed(key_pressed),
		.xout       (xout),
		.yout       (yout),
		.colourout  (colourout),
		.plot       (plot),
		.block_x    (block_x),
		.block_y    (block_y),
		.block_set  (block_set)
	);

	tb_pixel_checker i_checker (
		.clk      (clk),
		.plot     (plot),
		.xout     (xout),
		.yout     (yout),
		.colourout(colourout)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	always @(posedge clk) begin
		cyc <= cyc + 1;
		if (cyc >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cyc);
			$display("*** TEST FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] v;
		v = s ^ (s << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// queued commands plus the one being pushed, as the mover sees them in cycle n
	function automatic int queue_load(input int n);
		int load;
		load = 0;
		foreach (wr_edge[k]) begin
			if (wr_edge[k] <= n + 1)
				load++;
			if (pop_cyc[k] + 1 <= n)
				load--;        // read pointer moved at the edge after the pop
		end
		return load;
	endfunction

	// one command written at edge w, its pixels by the pixel rule
	function automatic void add_bar(input coord_t x, input coord_t y, input colour_t c,
	                                input logic vert, input int w);
		int p;
		int row_len;
		p = w;
		if (pop_cyc.size() > 0 && pop_cyc[$] + RASTER_T > p)
			p = pop_cyc[$] + RASTER_T;  // raster still busy
		wr_edge.push_back(w);
		pop_cyc.push_back(p);
		row_len = vert ? BAR_THICK : BAR_LEN;
		for (int i = 0; i < BAR_PIXELS; i++)
			i_checker.expect_pixel(coord_t'(x + i % row_len), coord_t'(y + i / row_len), c);
	endfunction

	function automatic void place_home(input logic vert, input int n);
		m_state = PLACING;
		m_x     = HOME_X;
		m_y     = HOME_Y;
		m_vert  = vert;
		m_set   = 1'b0;
		if (queue_load(n) <= QUEUE_DEPTH - 2)
			add_bar(HOME_X, HOME_Y, COLOUR_RED, vert, n + 2);
	endfunction

	// key strobe in cycle n, returns 1 when the bar moves
	function automatic bit apply_key(input key_code_t code, input int n);
		int nx;
		int ny;
		int w;
		int h;
		nx = m_x;
		ny = m_y;
		if (m_state != PLACING || queue_load(n) > QUEUE_DEPTH - 2 || last_move == n - 1)
			return 1'b0;
		if (code == KEY_SPACE) begin
			add_bar(m_x, m_y, COLOUR_PINK, m_vert, n + 2);
			m_state = SETTLED;
			m_set   = 1'b1;
			return 1'b0;
		end
		case (code)
			KEY_LEFT:  nx--;
			KEY_RIGHT: nx++;
			KEY_UP:    ny--;
			KEY_DOWN:  ny++;
			default:   return 1'b0;
		endcase
		w = m_vert ? BAR_THICK : BAR_LEN;
		h = m_vert ? BAR_LEN : BAR_THICK;
		if (nx < int'(MIN_X) || ny < int'(MIN_Y) ||
		    nx + w - 1 > int'(FIELD_MAX) || ny + h - 1 > int'(FIELD_MAX))
			return 1'b0;
		add_bar(m_x, m_y, COLOUR_BLACK, m_vert, n + 2); // erase old
		m_x = coord_t'(nx);
		m_y = coord_t'(ny);
		add_bar(m_x, m_y, COLOUR_RED, m_vert, n + 3);
		last_move = n;
		return 1'b1;
	endfunction

	function automatic void compare_val(input string name, input logic [7:0] exp,
	                                    input logic [7:0] got);
		if (got !== exp) begin
			$display("Fail at %0d ns: %s expected %0d got %0d", $time, name, exp, got);
			errors++;
		end
	endfunction

	function automatic void check_pos();
		compare_val("block_x", m_x, block_x);
		compare_val("block_y", m_y, block_y);
		compare_val("block_set", m_set, block_set);
	endfunction

	// ##############################
	// stimulus tasks
	// ##############################

	task automatic pulse_start(input logic vert);
		@(posedge clk);
		#1;
		vertical = vert;
		start    = 1'b1;
		place_home(vert, cyc);
		@(posedge clk);
		#1;
		start = 1'b0;
		repeat (KEY_GAP - 2) @(posedge clk);
		#1;
	endtask

	// next strobe can follow gap cycles after this one
	task automatic press_key(input key_code_t code, input int gap, output bit moved);
		@(posedge clk);
		#1;
		key_data    = code;
		key_pressed = 1'b1;
		moved       = apply_key(code, cyc);
		@(posedge clk);
		#1;
		key_pressed = 1'b0;
		repeat (gap - 2) @(posedge clk);
		#1;
	endtask

	// press until the bar stops, then compare with the bound
	task automatic walk_to_edge(input key_code_t code, input logic [7:0] lim_val,
	                            input bit on_x);
		bit moved;
		int steps;
		moved = 1'b1;
		steps = 0;
		while (moved && steps < 128) begin
			press_key(code, KEY_GAP, moved);
			steps++;
		end
		compare_val(on_x ? "block_x" : "block_y", lim_val, on_x ? block_x : block_y);
	endtask

	// wait for every expected bar, bounded by the bars still owed
	task automatic drain();
		int limit;
		limit = (i_checker.pending() / BAR_PIXELS + 1) * RASTER_T + 20;
		while (i_checker.pending() > 0 && limit > 0) begin
			@(posedge clk);
			limit--;
		end
		if (i_checker.pending() > 0) begin
			$display("%0d ns: %0d expected pixels were never plotted", $time,
			         i_checker.pending());
			i_checker.flush();
			errors++;
		end
		repeat (4) @(posedge clk);
		#1;
	endtask

	task automatic end_test(input int num, input string name);
		int now_err;
		drain();
		check_pos();
		now_err = errors + i_checker.err_count + i_dut.i_asserts.fail_count;
		if (now_err == base_err) begin
			passed++;
			$display("test %0d, %s: passed", num, name);
		end else begin
			failed++;
			$display("test %0d, %s: %0d errors", num, name, now_err - base_err);
		end
		base_err = now_err;
	endtask

	// ##############################
	// test sequence
	// ##############################

	initial begin
		bit        moved;
		key_code_t steps [8];
		key_code_t burst [10];
		key_code_t code;
		reset_n     = 1'b1;  // reset is active high
		start       = 1'b0;
		vertical    = 1'b0;
		key_data    = '0;
		key_pressed = 1'b0;
		errors      = 0;
		base_err    = 0;
		passed      = 0;
		failed      = 0;
		m_state     = IDLE;
		m_x         = HOME_X;
		m_y         = HOME_Y;
		m_vert      = 1'b0;
		m_set       = 1'b0;
		last_move   = -100;
		rng         = 32'he716;
		steps = '{KEY_RIGHT, KEY_RIGHT, KEY_DOWN, KEY_DOWN, KEY_LEFT, KEY_UP, KEY_RIGHT, KEY_DOWN};
		burst = '{KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_RIGHT, KEY_DOWN,
		          KEY_DOWN, KEY_DOWN, KEY_LEFT, KEY_LEFT, KEY_LEFT};
		repeat (8) @(posedge clk);
		#1;
		reset_n = 1'b0;
		repeat (2) @(posedge clk);

		pulse_start(1'b0);
		end_test(1, "home bar after start");

		foreach (steps[k]) begin
			press_key(steps[k], KEY_GAP, moved);
			check_pos();
		end
		end_test(2, "arrow keys erase and redraw");

		for (int v = 0; v < 2; v++) begin
			pulse_start(v[0]);
			walk_to_edge(KEY_LEFT, MIN_X, 1'b1);
			walk_to_edge(KEY_UP, MIN_Y, 1'b0);
			walk_to_edge(KEY_RIGHT, FIELD_MAX - (v ? BAR_THICK : BAR_LEN) + 1, 1'b1);
			walk_to_edge(KEY_DOWN, FIELD_MAX - (v ? BAR_LEN : BAR_THICK) + 1, 1'b0);
			check_pos();
		end
		end_test(3, "bounds at all four edges");

		pulse_start(1'b0);
		press_key(KEY_RIGHT, KEY_GAP, moved);
		press_key(KEY_SPACE, KEY_GAP, moved);
		compare_val("block_set", 1, block_set);
		press_key(KEY_LEFT, KEY_GAP, moved);  // ignored once set
		press_key(KEY_DOWN, KEY_GAP, moved);
		check_pos();
		pulse_start(1'b0);
		end_test(4, "space sets the bar");

		pulse_start(1'b0);
		drain();                              // queue known empty before the burst
		foreach (burst[k])
			press_key(burst[k], 2, moved);
		end_test(5, "key burst with back-pressure");

		for (int v = 0; v < 2; v++) begin
			pulse_start(v[0]);
			for (int k = 0; k < 40; k++) begin
				rng = xorshift(rng);
				case (rng % 6)
					0:       code = KEY_LEFT;
					1:       code = KEY_RIGHT;
					2:       code = KEY_UP;
					3:       code = KEY_DOWN;
					default: code = rng[15:8]; // any scan code
				endcase
				press_key(code, KEY_GAP, moved);
			end
			drain();
			check_pos();
		end
		end_test(6, "random keys");

		$display("tests passed: %0d, failed: %0d, pixels checked: %0d",
		         passed, failed, i_checker.checked);
		if (failed == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verilog.f
hdl/block_pkg.sv
hdl/block_mover.sv
hdl/draw_queue.sv
hdl/block_raster.sv
hdl/block_placer.sv
testbench/tb_pixel_checker.sv
testbench/tb_block_asserts.sv
testbench/tb_block_placer.sv
